/* hdl/alu_path.sv */
module alu_path (
    input  exe_pkg::exe_req_t req,
    output exe_pkg::alu_out_t alu_out
);
    import exe_pkg::*;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] result;
    logic [4:0]      shamt;
    logic            add_ov;
    logic            sub_ov;
    logic            overflow;

    always_comb begin
        // first operand
        case (req.src1_sel)
            SRC1_SA: src1 = {{(XLEN-5){1'b0}}, req.imm[10:6]};
            SRC1_PC: src1 = req.pc;
            default: src1 = req.rs_value;
        endcase

        // second operand
        case (req.src2_sel)
            SRC2_IMM_SEXT: src2 = {{(XLEN-IMM_W){req.imm[IMM_W-1]}}, req.imm};
            SRC2_IMM_ZEXT: src2 = {{(XLEN-IMM_W){1'b0}}, req.imm};
            SRC2_EIGHT:    src2 = 32'd8;
            default:       src2 = req.rt_value;
        endcase

        sum   = src1 + src2;
        diff  = src1 - src2;
        shamt = src1[4:0];

        // signed overflow from the operand and result signs
        add_ov = (src1[XLEN-1] == src2[XLEN-1]) && (sum[XLEN-1] != src1[XLEN-1]);
        sub_ov = (src1[XLEN-1] != src2[XLEN-1]) && (diff[XLEN-1] != src1[XLEN-1]);

        overflow = 1'b0;
        case (req.alu_op)
            ALU_ADD: begin
                result   = sum;
                overflow = add_ov;
            end
            ALU_ADDU: result = sum;
            ALU_SUB: begin
                result   = diff;
                overflow = sub_ov;
            end
            ALU_SUBU: result = diff;
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, src1 < src2};
            end
            ALU_AND: result = src1 & src2;
            ALU_OR:  result = src1 | src2;
            ALU_XOR: result = src1 ^ src2;
            ALU_NOR: result = ~(src1 | src2);
            // shifts move src2 by the amount in src1
            ALU_SLL: result = src2 << shamt;
            ALU_SRL: result = src2 >> shamt;
            ALU_SRA: result = $signed(src2) >>> shamt;
            ALU_LUI: result = {req.imm, {(XLEN-IMM_W){1'b0}}};
            default: result = sum;
        endcase

        // only the trapping add and sub may raise overflow
        a_ov_only_trapping: assert (!overflow || req.alu_op inside {ALU_ADD, ALU_SUB})
            else $error("alu_path: overflow raised for op %s", req.alu_op.name());
    end

    assign alu_out = '{result: result, overflow: overflow};

endmodule

/* hdl/exe_commit.sv */
module exe_commit (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  exe_pkg::exe_req_t  req,
    input  exe_pkg::alu_out_t  alu_out,
    input  exe_pkg::mem_out_t  mem_out,
    output logic               out_valid,
    output exe_pkg::exe_resp_t out_resp,
    output exe_pkg::mem_req_t  mem_req
);
    import exe_pkg::*;

    exc_code_e       exc;
    exe_resp_t       resp_d;
    logic [3:0]      wen_d;
    logic [3:0]      wen_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wdata_q;

    // overflow beats load fault beats store fault
    always_comb begin
        if (alu_out.overflow) begin
            exc = EXC_OV;
        end else if (mem_out.adel) begin
            exc = EXC_ADEL;
        end else if (mem_out.ades) begin
            exc = EXC_ADES;
        end else begin
            exc = EXC_NONE;
        end
    end

    always_comb begin
        resp_d.exc       = exc;
        resp_d.result    = alu_out.result;
        resp_d.dest      = req.dest;
        resp_d.gr_we     = req.gr_we && (exc == EXC_NONE);
        resp_d.pc        = req.pc;
        resp_d.bad_vaddr = (exc == EXC_ADEL || exc == EXC_ADES) ? mem_out.addr : '0;
        // kept for the load merge in the memory stage
        resp_d.mem_op    = req.mem_op;
        resp_d.byte_off  = mem_out.addr[1:0];
    end

    assign wen_d = (in_valid && exc == EXC_NONE) ? mem_out.wen : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            wen_q     <= 4'b0000;
        end else begin
            out_valid <= in_valid;
            wen_q     <= wen_d;
        end
    end

    // held until the next strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_resp <= resp_d;
            addr_q   <= mem_out.addr;
            wdata_q  <= mem_out.wdata;
        end
    end

    assign mem_req = '{wen: wen_q, addr: addr_q, wdata: wdata_q};

    a_valid_follows: assert property (@(posedge clk) disable iff (reset)
        in_valid |=> out_valid)
        else $error("exe_commit: strobe not answered on the next cycle");

    // a write only leaves with a valid response that carries no exception
    a_wen_clean_resp: assert property (@(posedge clk) disable iff (reset)
        mem_req.wen != 4'b0000 |-> out_valid && out_resp.exc == EXC_NONE)
        else $error("exe_commit: write enables on an idle or faulting cycle");

endmodule

/* hdl/exe_pkg.sv */
package exe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int IMM_W  = 16;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_LWL,
        MEM_LWR,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SWL,
        MEM_SWR
    } mem_op_e;

    typedef enum logic [1:0] {
        SRC1_RS,
        SRC1_SA,
        SRC1_PC
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RT,
        SRC2_IMM_SEXT,
        SRC2_IMM_ZEXT,
        SRC2_EIGHT
    } src2_sel_e;

    // listed lowest to highest code, priority is OV first
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OV,
        EXC_ADEL,
        EXC_ADES
    } exc_code_e;

    // one decoded instruction from the decode stage
    typedef struct packed {
        alu_op_e           alu_op;
        mem_op_e           mem_op;
        src1_sel_e         src1_sel;
        src2_sel_e         src2_sel;
        logic [XLEN-1:0]   rs_value;
        logic [XLEN-1:0]   rt_value;
        logic [IMM_W-1:0]  imm;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] dest;
        logic              gr_we;
    } exe_req_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            overflow;
    } alu_out_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [3:0]      wen;
        logic [XLEN-1:0] wdata;
        logic            adel;
        logic            ades;
    } mem_out_t;

    // data memory write port
    typedef struct packed {
        logic [3:0]      wen;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        exc_code_e         exc;
        logic [XLEN-1:0]   result;
        logic [REG_AW-1:0] dest;
        logic              gr_we;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   bad_vaddr;
        mem_op_e           mem_op;
        logic [1:0]        byte_off;
    } exe_resp_t;

endpackage

/* hdl/exe_top.sv */
module exe_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  exe_pkg::exe_req_t  in_req,
    output logic               out_valid,
    output exe_pkg::exe_resp_t out_resp,
    output exe_pkg::mem_req_t  mem_req
);
    import exe_pkg::*;

    alu_out_t alu_out;
    mem_out_t mem_out;

    // arithmetic and memory paths both see the raw request
    alu_path u_alu_path (
        .req     (in_req),
        .alu_out (alu_out)
    );

    mem_access u_mem_access (
        .req     (in_req),
        .mem_out (mem_out)
    );

    exe_commit u_exe_commit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .req       (in_req),
        .alu_out   (alu_out),
        .mem_out   (mem_out),
        .out_valid (out_valid),
        .out_resp  (out_resp),
        .mem_req   (mem_req)
    );

endmodule

/* hdl/mem_access.sv */
module mem_access (
    input  exe_pkg::exe_req_t req,
    output exe_pkg::mem_out_t mem_out
);
    import exe_pkg::*;

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] addr;
    logic [1:0]      off;
    logic [3:0]      wen;
    logic [XLEN-1:0] wdata;
    logic            adel;
    logic            ades;
    logic            is_store;

    always_comb begin
        imm_sext = {{(XLEN-IMM_W){req.imm[IMM_W-1]}}, req.imm};
        addr     = req.rs_value + imm_sext;
        off      = addr[1:0];

        // halfword needs even, word needs the low pair clear
        adel = ((req.mem_op == MEM_LH || req.mem_op == MEM_LHU) && off[0])
            || (req.mem_op == MEM_LW && off != 2'b00);
        ades = (req.mem_op == MEM_SH && off[0])
            || (req.mem_op == MEM_SW && off != 2'b00);

        is_store = req.mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};

        wen   = 4'b0000;
        wdata = req.rt_value;
        case (req.mem_op)
            MEM_SB: begin
                wen   = 4'b0001 << off;
                wdata = {4{req.rt_value[7:0]}};
            end
            MEM_SH: begin
                wen   = off[1] ? 4'b1100 : 4'b0011;
                wdata = {2{req.rt_value[15:0]}};
            end
            MEM_SW: begin
                wen = 4'b1111;
            end
            // left part lands in the low lanes
            MEM_SWL: begin
                case (off)
                    2'd0: begin
                        wen   = 4'b0001;
                        wdata = req.rt_value >> 24;
                    end
                    2'd1: begin
                        wen   = 4'b0011;
                        wdata = req.rt_value >> 16;
                    end
                    2'd2: begin
                        wen   = 4'b0111;
                        wdata = req.rt_value >> 8;
                    end
                    default: begin
                        wen   = 4'b1111;
                        wdata = req.rt_value;
                    end
                endcase
            end
            // right part lands in the high lanes
            MEM_SWR: begin
                case (off)
                    2'd0: begin
                        wen   = 4'b1111;
                        wdata = req.rt_value;
                    end
                    2'd1: begin
                        wen   = 4'b1110;
                        wdata = req.rt_value << 8;
                    end
                    2'd2: begin
                        wen   = 4'b1100;
                        wdata = req.rt_value << 16;
                    end
                    default: begin
                        wen   = 4'b1000;
                        wdata = req.rt_value << 24;
                    end
                endcase
            end
            default: begin
                wen = 4'b0000;
            end
        endcase

        a_wen_store_only: assert (wen == 4'b0000 || is_store)
            else $error("mem_access: byte enables %b on op %s", wen, req.mem_op.name());
    end

    assign mem_out = '{addr: addr, wen: wen, wdata: wdata, adel: adel, ades: ades};

endmodule

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -f src.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* sim/exe_checker.sv */
module exe_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  exe_pkg::exe_req_t  in_req,
    input  logic               out_valid,
    input  exe_pkg::exe_resp_t out_resp,
    input  exe_pkg::mem_req_t  mem_req,
    input  logic [2:0]         test_id,
    input  logic               test_end,
    output int                 total_checks,
    output int                 total_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import exe_pkg::*;

    logic       armed = 1'b0;
    logic       have_resp = 1'b0;
    logic       was_reset;
    logic       was_valid;
    logic       report_due;
    logic [2:0] report_id;
    exe_req_t   was_req;
    exe_resp_t  exp_resp;
    exe_resp_t  held_resp;
    mem_req_t   exp_mem;
    int         test_checks = 0;
    int         test_errors = 0;
    int         n_checks = 0;
    int         n_errors = 0;

    assign total_checks = n_checks;
    assign total_errors = n_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "alu ops";
            3'd2:    return "overflow";
            3'd3:    return "store lanes";
            3'd4:    return "address errors";
            default: return "strobes and gaps";
        endcase
    endfunction

    // expected outcome of one request
    function automatic void ref_model(input exe_req_t req, output exe_resp_t resp,
                                      output mem_req_t mreq);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] ea;
        logic [31:0] wdata;
        logic [3:0]  wen;
        logic [1:0]  off;
        longint      wide;
        logic        ov;
        logic        adel;
        logic        ades;
        case (req.src1_sel)
            SRC1_PC: a = req.pc;
            SRC1_SA: a = 32'(req.imm[10:6]);
            default: a = req.rs_value;
        endcase
        case (req.src2_sel)
            SRC2_IMM_SEXT: b = 32'($signed(req.imm));
            SRC2_IMM_ZEXT: b = 32'(req.imm);
            SRC2_EIGHT:    b = 32'd8;
            default:       b = req.rt_value;
        endcase
        // exact sum or difference; overflow when it does not fit in 32 bits
        wide = (req.alu_op inside {ALU_SUB, ALU_SUBU})
            ? longint'($signed(a)) - longint'($signed(b))
            : longint'($signed(a)) + longint'($signed(b));
        res = wide[31:0];
        ov  = (req.alu_op inside {ALU_ADD, ALU_SUB}) && (wide != longint'($signed(res)));
        case (req.alu_op)
            ALU_SLT:  res = {31'b0, longint'($signed(a)) < longint'($signed(b))};
            ALU_SLTU: res = {31'b0, a < b};
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_NOR:  res = ~(a | b);
            ALU_SLL:  res = b << a[4:0];
            ALU_SRL:  res = b >> a[4:0];
            ALU_SRA:  res = 32'($signed(b) >>> a[4:0]);
            ALU_LUI:  res = {req.imm, 16'h0000};
            default:  ;
        endcase
        ea   = req.rs_value + 32'($signed(req.imm));
        off  = ea[1:0];
        adel = (req.mem_op inside {MEM_LH, MEM_LHU} && off[0])
            || (req.mem_op == MEM_LW && off != 2'b00);
        ades = (req.mem_op == MEM_SH && off[0]) || (req.mem_op == MEM_SW && off != 2'b00);
        case (req.mem_op)
            MEM_SB:  wen = 4'b0001 << off;
            MEM_SH:  wen = off[1] ? 4'b1100 : 4'b0011;
            MEM_SW:  wen = 4'b1111;
            MEM_SWL: wen = 4'b1111 >> (3 - off);
            MEM_SWR: wen = 4'b1111 << off;
            default: wen = 4'b0000;
        endcase
        case (req.mem_op)
            MEM_SB:  wdata = {4{req.rt_value[7:0]}};
            MEM_SH:  wdata = {2{req.rt_value[15:0]}};
            MEM_SWL: wdata = req.rt_value >> (8 * (3 - off));
            MEM_SWR: wdata = req.rt_value << (8 * off);
            default: wdata = req.rt_value;
        endcase
        resp.exc       = ov ? EXC_OV : adel ? EXC_ADEL : ades ? EXC_ADES : EXC_NONE;
        resp.result    = res;
        resp.dest      = req.dest;
        resp.gr_we     = req.gr_we && resp.exc == EXC_NONE;
        resp.pc        = req.pc;
        resp.bad_vaddr = (resp.exc == EXC_ADEL || resp.exc == EXC_ADES) ? ea : 32'h0;
        resp.mem_op    = req.mem_op;
        resp.byte_off  = off;
        mreq.wen       = resp.exc == EXC_NONE ? wen : 4'b0000;
        mreq.addr      = ea;
        mreq.wdata     = wdata;
    endfunction

    task automatic record_check(input logic ok, input string msg);
        test_checks++;
        n_checks++;
        if (!ok) begin
            test_errors++;
            n_errors++;
            $display("ERROR at %0d ns: %s", $time, msg);
        end
    endtask

    // inputs settle on the falling edge, so the rising edge sees what the DUT sees
    always @(posedge clk) begin
        armed      <= 1'b1;
        was_reset  <= reset;
        was_valid  <= in_valid;
        was_req    <= in_req;
        report_due <= test_end;
        report_id  <= test_id;
    end

    always @(negedge clk) begin
        if (armed) begin
            if (!was_reset && was_valid) begin
                ref_model(was_req, exp_resp, exp_mem);
                record_check(out_valid === 1'b1, "out_valid missing one cycle after a strobe");
                record_check(out_resp === exp_resp,
                    $sformatf("response for pc %h is %h, expected %h",
                        was_req.pc, out_resp, exp_resp));
                record_check(mem_req.wen === exp_mem.wen,
                    $sformatf("wen %b, expected %b", mem_req.wen, exp_mem.wen));
                record_check(mem_req.addr === exp_mem.addr,
                    $sformatf("addr %h, expected %h", mem_req.addr, exp_mem.addr));
                if (exp_mem.wen != 4'b0000) begin
                    record_check(mem_req.wdata === exp_mem.wdata,
                        $sformatf("wdata %h, expected %h", mem_req.wdata, exp_mem.wdata));
                end
                held_resp = exp_resp;
                have_resp = 1'b1;
            end else begin
                record_check(out_valid === 1'b0, "out_valid high without a strobe");
                record_check(mem_req.wen === 4'b0000, "write enable active without a strobe");
                if (have_resp && !was_reset) begin
                    record_check(out_resp === held_resp, "response changed without a strobe");
                end
            end
            if (report_due) begin
                $display("test %0d %s: %0d checks, %0d errors", report_id,
                    test_name(report_id), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

/* sim/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import exe_pkg::*;

    localparam int RESET_CYCLES = 4;
    // strobe and idle cycles of the five tests, plus a four cycle drain after each
    localparam int TEST_CYCLES  = 300 + 196 + 80 + 108 + 100 + 5 * 4;
    localparam int MAX_CYCLES   = RESET_CYCLES + TEST_CYCLES + 50;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    exe_req_t    in_req;
    logic        out_valid;
    exe_resp_t   out_resp;
    mem_req_t    mem_req;
    logic [2:0]  test_id;
    logic        test_end;
    int          total_checks;
    int          total_errors;
    int          cycles = 0;
    logic [31:0] lcg_state = 32'h70ea_db40;
    exe_req_t    req;

    always #2 clk = ~clk;

    exe_top DUT (.*);

    exe_checker u_checker (.*);

    function logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function int pick(input int n);
        logic [31:0] v;
        v = rand32();
        return int'(v[30:8]) % n;
    endfunction

    // sign boundary operands
    function logic [31:0] edge_value(input int k);
        case (k)
            0:       return 32'h7fff_ffff;
            1:       return 32'h8000_0000;
            2:       return 32'h0000_0001;
            3:       return 32'hffff_ffff;
            4:       return 32'h7fff_fffe;
            5:       return 32'h8000_0001;
            default: return 32'h0000_0000;
        endcase
    endfunction

    function exe_req_t random_req(input logic with_mem);
        exe_req_t    r;
        logic [31:0] v;
        r.alu_op   = alu_op_e'(4'(pick(14)));
        r.mem_op   = with_mem ? mem_op_e'(4'(pick(13))) : MEM_NONE;
        r.src1_sel = src1_sel_e'(2'(pick(3)));
        r.src2_sel = src2_sel_e'(2'(pick(4)));
        r.rs_value = rand32();
        r.rt_value = rand32();
        r.pc       = rand32() & ~32'h3;
        v          = rand32();
        r.imm      = v[15:0];
        r.dest     = v[20:16];
        r.gr_we    = v[31];
        return r;
    endfunction

    // load or store whose effective address ends in off
    function exe_req_t access_req(input mem_op_e op, input int off);
        exe_req_t    r;
        logic [31:0] v;
        r          = random_req(1'b0);
        v          = rand32();
        r.alu_op   = ALU_ADDU;
        r.mem_op   = op;
        r.src1_sel = SRC1_RS;
        r.src2_sel = SRC2_IMM_SEXT;
        r.rs_value = r.rs_value & ~32'h3;
        r.imm      = {v[15:2], 2'(off)};
        r.gr_we    = !(op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR});
        return r;
    endfunction

    task send(input exe_req_t r);
        @(negedge clk);
        in_valid = 1'b1;
        in_req   = r;
    endtask

    // request bus keeps moving while the strobe is low
    task idle();
        @(negedge clk);
        in_valid = 1'b0;
        in_req   = random_req(1'b1);
    endtask

    task end_test();
        idle();
        idle();
        @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
        test_id  = test_id + 3'd1;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_req   = '0;
        test_id  = 3'd1;
        test_end = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        repeat (300) send(random_req(1'b0));
        end_test();

        // first four opcodes are ADD, ADDU, SUB, SUBU
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 7; i++) begin
                for (int j = 0; j < 7; j++) begin
                    req          = random_req(1'b0);
                    req.alu_op   = alu_op_e'(4'(op));
                    req.src1_sel = SRC1_RS;
                    req.src2_sel = SRC2_RT;
                    req.rs_value = edge_value(i);
                    req.rt_value = edge_value(j);
                    req.gr_we    = 1'b1;
                    send(req);
                end
            end
        end
        end_test();

        // SB through SWR are consecutive codes
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < 5; k++) begin
                for (int off = 0; off < 4; off++) begin
                    send(access_req(mem_op_e'(4'(int'(MEM_SB) + k)), off));
                end
            end
        end
        end_test();

        // LB..LWR, then SH and SW
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 9; k++) begin
                for (int off = 0; off < 4; off++) begin
                    send(access_req(mem_op_e'(4'(k < 7 ? k + 1 : k + 2)), off));
                end
            end
        end
        end_test();

        repeat (100) begin
            if (pick(2) == 0)
                send(random_req(1'b1));
            else
                idle();
        end
        end_test();

        // last checks and report go out on the falling edge just passed
        @(posedge clk);
        $display("summary: %0d checks, %0d errors over 5 tests", total_checks, total_errors);
        if (total_errors == 0 && total_checks > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/exe_pkg.sv
hdl/alu_path.sv
hdl/mem_access.sv
hdl/exe_commit.sv
hdl/exe_top.sv
sim/exe_checker.sv
sim/tb_top.sv
